/* verilog.f */
+incdir+design
design/isaPkg.sv
design/memPkg.sv
design/memBusIf.sv
design/programRam.sv
design/regFile.sv
design/aluUnit.sv
design/controlSequencer.sv
design/srcCpuTop.sv
tb/srcCpuTb.sv

/* Makefile */
# Verilator build, run and lint for the SRC core

.PHONY: all run lint clean

all: run

obj_dir/VsrcCpuTb: verilog.f design/*.sv design/*.svh tb/*.sv
	verilator --binary --timing -f verilog.f --top-module srcCpuTb

run: obj_dir/VsrcCpuTb
	-./obj_dir/VsrcCpuTb > sim.log 2>&1
	cat sim.log
	@if grep -q "TB FAILED" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "TB PASSED" sim.log || (echo "simulation did not complete"; exit 1)

lint:
	verilator --lint-only --timing -f verilog.f --top-module srcCpuTop

clean:
	rm -rf obj_dir sim.log

/* tb/srcCpuTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "srcCpu_macros.svh"

module srcCpuTb;

  import isaPkg::*;
  import memPkg::*;

  localparam int NumProgs      = 6;
  localparam int MaxWords      = 32;   // image loaded per program
  localparam int MaxOuts       = 8;
  localparam int TimeoutCycles = 200;  // per wait
  localparam int HaltWatch     = 16;   // cycles watched after halt

  logic     clk;
  logic     arstN;
  logic     run;
  logic     loadEn;
  memAddrT  loadAddr;
  memDataT  loadData;
  dataWordT inPort;
  dataWordT outPort;
  logic     outValid;
  logic     halted;

  dataWordT progWords [NumProgs][MaxWords];  // program image indexed by address
  dataWordT expOuts [NumProgs][MaxOuts];     // out values in order
  int       expCount [NumProgs];
  dataWordT inVal [NumProgs];                // value held on inPort
  logic     expHalt [NumProgs];
  integer   seed;

  srcCpuTop DUT (
    .clk      (clk),
    .arstN    (arstN),
    .run      (run),
    .loadEn   (loadEn),
    .loadAddr (loadAddr),
    .loadData (loadData),
    .inPort   (inPort),
    .outPort  (outPort),
    .outValid (outValid),
    .halted   (halted)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  // register-register form with rc in bits 18:15
  function automatic dataWordT encReg(opcodeE op, regIdxT ra, regIdxT rb, regIdxT rc);
    return {op, ra, rb, rc, 15'd0};
  endfunction

  // constant form with a 19-bit signed field
  function automatic dataWordT encImm(opcodeE op, regIdxT ra, regIdxT rb, int c);
    logic [18:0] c19;
    c19 = c[18:0];
    return {op, ra, rb, c19};
  endfunction

  // branch with the condition in bits 20:19
  function automatic dataWordT encBr(regIdxT ra, brCondE cond, int off);
    logic [18:0] off19;
    off19 = off[18:0];
    return {opBr, ra, 2'b00, cond, off19};
  endfunction

  task automatic failRun(string reason);
    $display("%s", reason);
    $display("TB FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkWord(string sigName, dataWordT expVal, dataWordT actVal);
    if (actVal !== expVal) begin
      $display("error: time %0t, %s expected %h, actual %h", $time, sigName, expVal, actVal);
      failRun("stopping at first mismatch");
    end
  endtask

  task automatic checkHalt(string sigName, logic expVal, logic actVal);
    if (actVal !== expVal) begin
      $display("error: time %0t, %s expected %b, actual %b", $time, sigName, expVal, actVal);
      failRun("stopping at first mismatch");
    end
  endtask

  task automatic putWord(int p, int addr, dataWordT w);
    progWords[p][addr] = w;
  endtask

  task automatic addOut(int p, dataWordT v);
    expOuts[p][expCount[p]] = v;  // appended in expected order
    expCount[p]++;
  endtask

  task automatic buildTable();
    for (int p = 0; p < NumProgs; p++) begin
      for (int i = 0; i < MaxWords; i++) begin
        progWords[p][i] = encImm(opNop, 0, 0, i);  // nop tagged with its own address
      end
      expCount[p] = 0;
      expHalt[p]  = 1'b1;
      inVal[p]    = $random(seed);
    end
    // ldi with r0 and r1 base, ld, st then ld back
    putWord(0, 0, encImm(opAddi, 0, 0, 50));   // r0 = 50 must not act as a base
    putWord(0, 1, encImm(opLdi, 1, 0, 100));   // r1 = 100
    putWord(0, 2, encImm(opLdi, 2, 1, -3));    // r2 = 97
    putWord(0, 3, encImm(opOut, 2, 0, 0));
    putWord(0, 4, encImm(opLd, 3, 0, 20));     // data word at 20
    putWord(0, 5, encImm(opOut, 3, 0, 0));
    putWord(0, 6, encImm(opSt, 3, 1, 5));      // mem[105] = r3
    putWord(0, 7, encImm(opLd, 4, 1, 5));
    putWord(0, 8, encImm(opAddi, 4, 4, 1));
    putWord(0, 9, encImm(opOut, 4, 0, 0));
    putWord(0, 10, encImm(opHalt, 0, 0, 0));
    putWord(0, 20, 32'h1234_5678);
    addOut(0, 32'd97);
    addOut(0, 32'h1234_5678);
    addOut(0, 32'h1234_5679);
    // arithmetic and logic
    putWord(1, 0, encImm(opAddi, 1, 0, -7));   // r1 = -7
    putWord(1, 1, encImm(opAddi, 2, 0, 12));
    putWord(1, 2, encReg(opAdd, 3, 1, 2));
    putWord(1, 3, encImm(opOut, 3, 0, 0));
    putWord(1, 4, encReg(opSub, 4, 1, 2));
    putWord(1, 5, encImm(opOut, 4, 0, 0));
    putWord(1, 6, encReg(opAnd, 5, 1, 2));
    putWord(1, 7, encReg(opOr, 6, 1, 2));
    putWord(1, 8, encImm(opOut, 5, 0, 0));
    putWord(1, 9, encImm(opOut, 6, 0, 0));
    putWord(1, 10, encImm(opAndi, 7, 4, 255));
    putWord(1, 11, encImm(opOri, 8, 2, -256)); // constant sign extends
    putWord(1, 12, encImm(opOut, 7, 0, 0));
    putWord(1, 13, encImm(opOut, 8, 0, 0));
    putWord(1, 14, encImm(opNeg, 9, 1, 0));
    putWord(1, 15, encImm(opNot, 10, 2, 0));
    putWord(1, 16, encImm(opOut, 9, 0, 0));
    putWord(1, 17, encImm(opOut, 10, 0, 0));
    putWord(1, 18, encImm(opHalt, 0, 0, 0));
    addOut(1, 32'd5);
    addOut(1, 32'hFFFF_FFED);  // -19
    addOut(1, 32'h0000_0008);
    addOut(1, 32'hFFFF_FFFD);
    addOut(1, 32'h0000_00ED);
    addOut(1, 32'hFFFF_FF0C);
    addOut(1, 32'd7);
    addOut(1, 32'hFFFF_FFF3);
    // shifts and rotates of a negative word by 4
    putWord(2, 0, encImm(opLdi, 1, 0, 4));     // shift amount
    putWord(2, 1, encImm(opLd, 2, 0, 24));
    putWord(2, 2, encReg(opShr, 3, 2, 1));
    putWord(2, 3, encReg(opShra, 4, 2, 1));
    putWord(2, 4, encReg(opShl, 5, 2, 1));
    putWord(2, 5, encReg(opRor, 6, 2, 1));
    putWord(2, 6, encReg(opRol, 7, 2, 1));
    for (int r = 3; r <= 7; r++) begin
      putWord(2, r + 4, encImm(opOut, regIdxT'(r), 0, 0));
    end
    putWord(2, 12, encImm(opHalt, 0, 0, 0));
    putWord(2, 24, 32'h8000_00F1);
    addOut(2, 32'h0800_000F);
    addOut(2, 32'hF800_000F);  // sign fill
    addOut(2, 32'h0000_0F10);
    addOut(2, 32'h1800_000F);
    addOut(2, 32'h0000_0F18);
    // branch tests with r1 = 0, r2 = 5 and r3 = -2
    // a skipped out would show up as an extra value
    putWord(3, 0, encImm(opAddi, 2, 0, 5));
    putWord(3, 1, encImm(opAddi, 3, 0, -2));
    putWord(3, 2, encBr(1, brZero, 1));        // taken
    putWord(3, 3, encImm(opOut, 2, 0, 0));
    putWord(3, 4, encBr(2, brZero, 1));        // not taken
    putWord(3, 5, encImm(opOut, 2, 0, 0));
    putWord(3, 6, encBr(2, brNonzero, 1));     // taken
    putWord(3, 7, encImm(opOut, 3, 0, 0));
    putWord(3, 8, encBr(1, brNonzero, 1));     // not taken
    putWord(3, 9, encImm(opOut, 3, 0, 0));
    putWord(3, 10, encBr(2, brPlus, 1));       // taken
    putWord(3, 11, encImm(opOut, 3, 0, 0));
    putWord(3, 12, encBr(3, brPlus, 1));       // not taken
    putWord(3, 13, encImm(opOut, 2, 0, 0));
    putWord(3, 14, encBr(3, brMinus, 1));      // taken
    putWord(3, 15, encImm(opOut, 2, 0, 0));
    putWord(3, 16, encBr(2, brMinus, 1));      // not taken
    putWord(3, 17, encImm(opOut, 3, 0, 0));
    putWord(3, 18, encImm(opAddi, 4, 0, 3));   // loop count
    putWord(3, 19, encImm(opOut, 4, 0, 0));
    putWord(3, 20, encImm(opAddi, 4, 4, -1));
    putWord(3, 21, encBr(4, brNonzero, -3));   // back to 19
    putWord(3, 22, encImm(opHalt, 0, 0, 0));
    addOut(3, 32'd5);
    addOut(3, 32'hFFFF_FFFE);
    addOut(3, 32'd5);
    addOut(3, 32'hFFFF_FFFE);
    addOut(3, 32'd3);
    addOut(3, 32'd2);
    addOut(3, 32'd1);
    // jal to 6 then jr back through the link register and finally in
    putWord(4, 0, encImm(opLdi, 1, 0, 6));
    putWord(4, 1, encImm(opJal, 1, 0, 0));     // link = 2
    putWord(4, 2, encImm(opOut, 2, 0, 0));
    putWord(4, 3, encImm(opIn, 3, 0, 0));
    putWord(4, 4, encImm(opOut, 3, 0, 0));
    putWord(4, 5, encImm(opHalt, 0, 0, 0));
    putWord(4, 6, encImm(opAddi, 2, 0, 77));
    putWord(4, 7, encImm(opOut, `SRC_LINK_REG, 0, 0));
    putWord(4, 8, encImm(opJr, `SRC_LINK_REG, 0, 0));
    addOut(4, 32'd2);
    addOut(4, 32'd77);
    addOut(4, inVal[4]);
    // nothing runs past halt
    putWord(5, 0, encImm(opAddi, 1, 0, 9));
    putWord(5, 1, encImm(opOut, 1, 0, 0));
    putWord(5, 2, encImm(opHalt, 0, 0, 0));
    putWord(5, 3, encImm(opOut, 1, 0, 0));     // must never appear
    addOut(5, 32'd9);
  endtask

  task automatic applyReset();
    @(negedge clk);
    arstN  = 1'b0;
    run    = 1'b0;
    loadEn = 1'b0;
    repeat (8) @(negedge clk);
    arstN = 1'b1;
  endtask

  // host port writes while the core is idle
  task automatic loadProgram(int p);
    for (int i = 0; i < MaxWords; i++) begin
      @(negedge clk);
      loadEn   = 1'b1;
      loadAddr = memAddrT'(i);
      loadData = progWords[p][i];
    end
    @(negedge clk);
    loadEn = 1'b0;
  endtask

  task automatic waitOut(output dataWordT value);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!outValid) begin
      if (halted) failRun("core halted before all expected out values");
      if (cycles >= TimeoutCycles) failRun("timeout waiting for an out pulse");
      cycles++;
      @(negedge clk);
    end
    value = outPort;  // stable mid-cycle
  endtask

  task automatic waitHalt();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!halted) begin
      if (outValid) failRun("extra out pulse before halt");
      if (cycles >= TimeoutCycles) failRun("timeout waiting for halted");
      cycles++;
      @(negedge clk);
    end
  endtask

  task automatic watchHalted(int p);
    repeat (HaltWatch) begin
      @(negedge clk);
      checkHalt("halted", expHalt[p], halted);  // sticky until reset
      checkHalt("outValid", 1'b0, outValid);
    end
  endtask

  initial begin
    dataWordT got;
    arstN    = 1'b0;
    run      = 1'b0;
    loadEn   = 1'b0;
    loadAddr = '0;
    loadData = '0;
    inPort   = '0;
    seed     = 64523;
    buildTable();
    for (int p = 0; p < NumProgs; p++) begin
      applyReset();
      loadProgram(p);
      checkHalt("outValid", 1'b0, outValid);  // idle before run
      checkHalt("halted", 1'b0, halted);
      checkWord("outPort", '0, outPort);
      inPort = inVal[p];
      run    = 1'b1;
      for (int k = 0; k < expCount[p]; k++) begin
        waitOut(got);
        checkWord($sformatf("outPort[%0d]", k), expOuts[p][k], got);
      end
      if (expHalt[p]) waitHalt();
      watchHalted(p);
      $display("program %0d done, %0d out values", p, expCount[p]);
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* design/srcCpuTop.sv */
`timescale 1ns/1ps
`default_nettype none

module srcCpuTop (
  input  logic              clk,
  input  logic              arstN,
  input  logic              run,       // start from address 0
  input  logic              loadEn,    // host memory load
  input  memPkg::memAddrT   loadAddr,
  input  memPkg::memDataT   loadData,
  input  isaPkg::dataWordT  inPort,
  output isaPkg::dataWordT  outPort,
  output logic              outValid,  // one pulse per out
  output logic              halted
);

  import isaPkg::*;

  memBusIf memBus ();  // core to memory

  regIdxT   rdIdxA, rdIdxB, wrIdx;
  dataWordT rdDataA, rdDataB, wrData;
  logic     wrEn;
  aluOpE    aluOp;
  dataWordT aluA, aluB, aluResult;

  programRam uRam (
    .clk      (clk),
    .bus      (memBus.responder),
    .loadEn   (loadEn),
    .loadAddr (loadAddr),
    .loadData (loadData)
  );

  regFile uRegs (
    .clk     (clk),
    .arstN   (arstN),
    .rdIdxA  (rdIdxA),
    .rdIdxB  (rdIdxB),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB),
    .wrEn    (wrEn),
    .wrIdx   (wrIdx),
    .wrData  (wrData)
  );

  aluUnit uAlu (
    .aluOp     (aluOp),
    .aluA      (aluA),
    .aluB      (aluB),
    .aluResult (aluResult)
  );

  controlSequencer uCtrl (
    .clk       (clk),
    .arstN     (arstN),
    .run       (run),
    .inPort    (inPort),
    .bus       (memBus.requester),
    .rdIdxA    (rdIdxA),
    .rdIdxB    (rdIdxB),
    .rdDataA   (rdDataA),
    .rdDataB   (rdDataB),
    .wrEn      (wrEn),
    .wrIdx     (wrIdx),
    .wrData    (wrData),
    .aluOp     (aluOp),
    .aluA      (aluA),
    .aluB      (aluB),
    .aluResult (aluResult),
    .outPort   (outPort),
    .outValid  (outValid),
    .halted    (halted)
  );

endmodule

`default_nettype wire

/* design/controlSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "srcCpu_macros.svh"

module controlSequencer (
  input  logic              clk,
  input  logic              arstN,
  input  logic              run,
  input  isaPkg::dataWordT  inPort,
  memBusIf.requester        bus,
  output isaPkg::regIdxT    rdIdxA,
  output isaPkg::regIdxT    rdIdxB,
  input  isaPkg::dataWordT  rdDataA,
  input  isaPkg::dataWordT  rdDataB,
  output logic              wrEn,
  output isaPkg::regIdxT    wrIdx,
  output isaPkg::dataWordT  wrData,
  output isaPkg::aluOpE     aluOp,
  output isaPkg::dataWordT  aluA,
  output isaPkg::dataWordT  aluB,
  input  isaPkg::dataWordT  aluResult,
  output isaPkg::dataWordT  outPort,
  output logic              outValid,
  output logic              halted
);

  import isaPkg::*;
  import memPkg::*;

  cpuStateE state, stateNext;
  memAddrT  pc;        // points past the current instruction once it is in ir
  dataWordT ir;
  opcodeE   opcode;
  regIdxT   ra, rb, rc;
  brCondE   cond;
  dataWordT constExt;  // sign-extended 19-bit constant
  logic     rrForm;    // register-register, rc is an operand
  logic     memForm;   // ld, ldi, st use the r0-is-zero base rule
  logic     useRa;     // ALU passes R[ra] through
  logic     brTaken;
  memAddrT  brTarget;
  dataWordT wbData;    // value for the writeBack cycle
  regIdxT   wbIdx;
  logic     wbEn;

  // instruction fields
  assign opcode   = opcodeE'(ir[31:27]);
  assign ra       = ir[26:23];
  assign rb       = ir[22:19];
  assign rc       = ir[18:15];
  assign cond     = brCondE'(ir[20:19]);
  assign constExt = {{(`SRC_WORD_W-19){ir[18]}}, ir[18:0]};

  // decode, ALU control
  always_comb begin
    rrForm  = 1'b0;
    memForm = 1'b0;
    useRa   = 1'b0;
    case (opcode)
      opLd, opLdi, opSt: begin aluOp = aluAdd; memForm = 1'b1; end
      opAdd:  begin aluOp = aluAdd;  rrForm = 1'b1; end
      opSub:  begin aluOp = aluSub;  rrForm = 1'b1; end
      opAnd:  begin aluOp = aluAnd;  rrForm = 1'b1; end
      opOr:   begin aluOp = aluOr;   rrForm = 1'b1; end
      opShr:  begin aluOp = aluShr;  rrForm = 1'b1; end
      opShra: begin aluOp = aluShra; rrForm = 1'b1; end
      opShl:  begin aluOp = aluShl;  rrForm = 1'b1; end
      opRor:  begin aluOp = aluRor;  rrForm = 1'b1; end
      opRol:  begin aluOp = aluRol;  rrForm = 1'b1; end
      opAddi: aluOp = aluAdd;
      opAndi: aluOp = aluAnd;
      opOri:  aluOp = aluOr;
      opNeg:  aluOp = aluNeg;
      opNot:  aluOp = aluNot;
      opBr, opJr, opJal, opOut: begin aluOp = aluPass; useRa = 1'b1; end
      default: aluOp = aluPass;  // in, nop, halt, unused codes
    endcase
  end

  // register reads: port A is rb, port B is rc or ra
  assign rdIdxA = rb;
  assign rdIdxB = rrForm ? rc : ra;

  assign aluA = useRa ? rdDataB :
                (memForm && rb == '0) ? '0 : rdDataA;  // r0 base means no base
  assign aluB = rrForm ? rdDataB : constExt;

  // branch test on R[ra], passed through the ALU
  always_comb begin
    case (cond)
      brZero:    brTaken = (aluResult == '0);
      brNonzero: brTaken = (aluResult != '0);
      brPlus:    brTaken = !aluResult[`SRC_WORD_W-1];
      default:   brTaken =  aluResult[`SRC_WORD_W-1];  // minus
    endcase
  end

  assign brTarget = pc + constExt[`SRC_ADDR_W-1:0];  // pc already holds own PC + 1

  // memory strobes, writeBack also fetches the next word
  assign bus.read  = (state == stFetch) || (state == stWriteBack) ||
                     (state == stExecute && opcode == opLd);
  assign bus.write = (state == stExecute && opcode == opSt);
  assign bus.addr  = (state == stExecute) ? aluResult[`SRC_ADDR_W-1:0] : pc;
  assign bus.wrData = rdDataB;  // R[ra] for st

  // register write in writeBack only
  assign wrEn   = wbEn && (state == stWriteBack);
  assign wrIdx  = wbIdx;
  assign wrData = wbData;

  assign halted = (state == stHalted);

  always_comb begin
    stateNext = state;
    case (state)
      stIdle:      if (run) stateNext = stFetch;
      stFetch:     stateNext = stFetchWait;
      stFetchWait: stateNext = stExecute;
      stExecute: begin
        if (opcode == opHalt)    stateNext = stHalted;
        else if (opcode == opLd) stateNext = stMemWait;
        else                     stateNext = stWriteBack;
      end
      stMemWait:   stateNext = stWriteBack;
      stWriteBack: stateNext = stFetchWait;  // next word already requested
      default:     stateNext = stHalted;     // stays until reset
    endcase
  end

  // control state
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state    <= stIdle;
      pc       <= '0;
      wbEn     <= 1'b0;
      outPort  <= '0;
      outValid <= 1'b0;
    end else begin
      state    <= stateNext;
      outValid <= 1'b0;  // single-cycle pulse
      case (state)
        stIdle:      pc <= '0;
        stFetchWait: pc <= pc + 1'b1;
        stExecute: begin
          wbEn <= opcode inside {opLd, opLdi, opAdd, opSub, opAnd, opOr, opShr,
                                 opShra, opShl, opRor, opRol, opAddi, opAndi,
                                 opOri, opNeg, opNot, opJal, opIn};
          if (opcode == opBr && brTaken) pc <= brTarget;
          if (opcode == opJr || opcode == opJal) pc <= aluResult[`SRC_ADDR_W-1:0];
          if (opcode == opOut) begin
            outPort  <= aluResult;  // R[ra]
            outValid <= 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  // instruction and writeback payload
  always_ff @(posedge clk) begin
    if (state == stFetchWait) ir <= bus.rdData;
    if (state == stExecute) begin
      wbIdx <= (opcode == opJal) ? regIdxT'(`SRC_LINK_REG) : ra;
      if (opcode == opIn)       wbData <= inPort;
      else if (opcode == opJal) wbData <= dataWordT'(pc);  // return address
      else                      wbData <= aluResult;
    end
    if (state == stMemWait) wbData <= bus.rdData;  // ld data
  end

endmodule

`default_nettype wire

/* design/aluUnit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "srcCpu_macros.svh"

module aluUnit (
  input  isaPkg::aluOpE     aluOp,
  input  isaPkg::dataWordT  aluA,
  input  isaPkg::dataWordT  aluB,
  output isaPkg::dataWordT  aluResult
);

  import isaPkg::*;

  localparam int ShW = $clog2(`SRC_WORD_W);  // shift amount width

  logic [ShW-1:0]            shamt;    // low bits of aluB
  logic [2*`SRC_WORD_W-1:0]  dblWord;  // aluA twice, for rotates
  logic [2*`SRC_WORD_W-1:0]  rorWide;
  logic [2*`SRC_WORD_W-1:0]  rolWide;

  assign shamt   = aluB[ShW-1:0];
  assign dblWord = {aluA, aluA};
  assign rorWide = dblWord >> shamt;  // low half is the rotated word
  assign rolWide = dblWord << shamt;  // high half is the rotated word

  always_comb begin
    case (aluOp)
      aluAdd:  aluResult = aluA + aluB;
      aluSub:  aluResult = aluA - aluB;
      aluAnd:  aluResult = aluA & aluB;
      aluOr:   aluResult = aluA | aluB;
      aluShr:  aluResult = aluA >> shamt;  // zero fill
      aluShra: aluResult = dataWordT'($signed(aluA) >>> shamt);  // sign fill
      aluShl:  aluResult = aluA << shamt;
      aluRor:  aluResult = rorWide[`SRC_WORD_W-1:0];
      aluRol:  aluResult = rolWide[2*`SRC_WORD_W-1:`SRC_WORD_W];
      aluNeg:  aluResult = -aluA;  // two's complement
      aluNot:  aluResult = ~aluA;
      default: aluResult = aluA;   // pass, used for branch test, jr, out
    endcase
  end

endmodule

`default_nettype wire

/* design/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "srcCpu_macros.svh"

module regFile (
  input  logic              clk,
  input  logic              arstN,
  input  isaPkg::regIdxT    rdIdxA,
  input  isaPkg::regIdxT    rdIdxB,
  output isaPkg::dataWordT  rdDataA,
  output isaPkg::dataWordT  rdDataB,
  input  logic              wrEn,
  input  isaPkg::regIdxT    wrIdx,
  input  isaPkg::dataWordT  wrData
);

  import isaPkg::*;

  dataWordT regs [`SRC_NUM_REGS];  // r0 is a plain register here

  // single synchronous write port
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < `SRC_NUM_REGS; i++) begin
        regs[i] <= '0;  // all registers start at zero
      end
    end else if (wrEn) begin
      regs[wrIdx] <= wrData;
    end
  end

  // two asynchronous read ports
  assign rdDataA = regs[rdIdxA];  // base / first operand
  assign rdDataB = regs[rdIdxB];  // second operand or ra

endmodule

`default_nettype wire

/* design/programRam.sv */
`timescale 1ns/1ps
`default_nettype none

`include "srcCpu_macros.svh"

module programRam (
  input  logic              clk,
  memBusIf.responder        bus,
  input  logic              loadEn,    // host load, wins over the core
  input  memPkg::memAddrT   loadAddr,
  input  memPkg::memDataT   loadData
);

  import memPkg::*;

  memDataT mem [`SRC_MEM_DEPTH];  // program and data share one array

  // write port: host first, then core store
  always_ff @(posedge clk) begin
    if (loadEn) begin
      mem[loadAddr] <= loadData;
    end else if (bus.write) begin
      mem[bus.addr] <= bus.wrData;
    end
  end

  // registered read, one cycle latency
  always_ff @(posedge clk) begin
    if (bus.read && !loadEn) begin
      bus.rdData <= mem[bus.addr];  // holds until the next read strobe
    end
  end

endmodule

`default_nettype wire

/* design/memBusIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface memBusIf;

  import memPkg::*;

  memAddrT addr;    // word address, shared by read and write
  memDataT wrData;  // store data
  memDataT rdData;  // valid the cycle after read, held until next strobe
  logic    read;    // one-cycle read strobe
  logic    write;   // one-cycle write strobe

  // core side
  modport requester (output addr, output wrData, output read, output write,
                     input rdData);

  // memory side
  modport responder (input addr, input wrData, input read, input write,
                     output rdData);

endinterface

`default_nettype wire

/* design/memPkg.sv */
`default_nettype none

package memPkg;

  `include "srcCpu_macros.svh"

  // word address into the program/data memory
  typedef logic [`SRC_ADDR_W-1:0] memAddrT;

  // one memory word, same width as a register
  typedef logic [`SRC_WORD_W-1:0] memDataT;

endpackage

`default_nettype wire

/* design/isaPkg.sv */
`default_nettype none

package isaPkg;

  `include "srcCpu_macros.svh"

  typedef logic [`SRC_WORD_W-1:0] dataWordT;            // register / data value
  typedef logic [$clog2(`SRC_NUM_REGS)-1:0] regIdxT;    // register number

  // opcode field, bits 31:27 of the instruction
  typedef enum logic [4:0] {
    opLd   = 5'd0,
    opLdi  = 5'd1,
    opSt   = 5'd2,
    opAdd  = 5'd3,
    opSub  = 5'd4,
    opAnd  = 5'd5,
    opOr   = 5'd6,
    opShr  = 5'd7,
    opShra = 5'd8,
    opShl  = 5'd9,
    opRor  = 5'd10,
    opRol  = 5'd11,
    opAddi = 5'd12,
    opAndi = 5'd13,
    opOri  = 5'd14,
    opNeg  = 5'd17,
    opNot  = 5'd18,
    opBr   = 5'd19,
    opJr   = 5'd20,
    opJal  = 5'd21,
    opIn   = 5'd22,
    opOut  = 5'd23,
    opNop  = 5'd26,
    opHalt = 5'd27
  } opcodeE;

  typedef enum logic [1:0] {
    brZero    = 2'd0,
    brNonzero = 2'd1,
    brPlus    = 2'd2,
    brMinus   = 2'd3
  } brCondE;

  typedef enum logic [3:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluShr, aluShra,
    aluShl, aluRor, aluRol, aluNeg, aluNot, aluPass
  } aluOpE;

  typedef enum logic [2:0] {
    stIdle, stFetch, stFetchWait, stExecute, stMemWait, stWriteBack, stHalted
  } cpuStateE;

endpackage

`default_nettype wire

/* design/srcCpu_macros.svh */
`ifndef SRC_CPU_MACROS_SVH
`define SRC_CPU_MACROS_SVH

// datapath and register width
`define SRC_WORD_W 32

// memory geometry, 512 words of 32 bits
`define SRC_ADDR_W 9
`define SRC_MEM_DEPTH 512

// register file size and jal target
`define SRC_NUM_REGS 16
`define SRC_LINK_REG 15

`endif
